/* Bender.yml */
package:
  name: kd_search

sources:
  - kd_tree_pkg.sv
  - internal_node.sv
  - kd_tree.sv
  - node_config_apb.sv
  - kd_search_top.sv
  - target: test
    files:
      - tb_kd_search.sv

/* internal_node.sv */
`timescale 1ns/1ps

module internal_node (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 wen,        // From APB decode
  input  logic                                 valid,
  input  logic                                 valid_two,
  input  logic [kd_tree_pkg::storage_width-1:0] wdata,
  input  kd_tree_pkg::patch_u                  patch_in,
  input  kd_tree_pkg::patch_u                  patch_in_two,
  output logic                                 valid_left,
  output logic                                 valid_right,
  output logic                                 valid_left_two,
  output logic                                 valid_right_two,
  output logic [kd_tree_pkg::storage_width-1:0] rdata
);

  logic [kd_tree_pkg::idx_width-1:0]        idx;         // Split dimension
  logic signed [kd_tree_pkg::dim_width-1:0] median;      // Split value
  kd_tree_pkg::node_word_t                  wr_word;
  kd_tree_pkg::node_word_t                  rd_word;
  logic signed [kd_tree_pkg::dim_width-1:0] sliced;      // Lane one selected dimension
  logic signed [kd_tree_pkg::dim_width-1:0] sliced_two;  // Lane two selected dimension
  logic                                     go_left;
  logic                                     go_left_two;

  // Pick one signed dimension out of a patch
  function automatic logic signed [kd_tree_pkg::dim_width-1:0] slice_dim(
    input kd_tree_pkg::patch_u               p,
    input logic [kd_tree_pkg::idx_width-1:0] sel
  );
    logic signed [kd_tree_pkg::dim_width-1:0] val;
    val = '0; // Index 5..7 reads as zero
    if (sel < kd_tree_pkg::num_dims) begin
      val = $signed(p.dims[sel]);
    end
    return val;
  endfunction

  assign wr_word = wdata; // Struct view of the write word

  // Split parameter storage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idx    <= kd_tree_pkg::idx_invalid;
      median <= '0;
    end else if (wen) begin
      idx    <= wr_word.idx;    // Only the low index bits are kept
      median <= wr_word.median;
    end
  end

  assign sliced     = slice_dim(patch_in, idx);
  assign sliced_two = slice_dim(patch_in_two, idx);

  // Signed compare, ties go right
  assign go_left     = sliced < median;
  assign go_left_two = sliced_two < median;

  assign valid_left      = valid && go_left;
  assign valid_right     = valid && !go_left;
  assign valid_left_two  = valid_two && go_left_two;
  assign valid_right_two = valid_two && !go_left_two;

  // Readback word with the pad cleared
  always_comb begin
    rd_word        = '0;
    rd_word.median = median;
    rd_word.idx    = idx;
  end

  assign rdata = rd_word;

  // A valid patch leaves through exactly one side in each lane
  a_one_side: assert property (@(posedge clk) disable iff (!rst_n)
    !(valid_left && valid_right) && !(valid_left_two && valid_right_two))
    else $error("internal_node: left and right valid together");

endmodule

/* kd_search_top.sv */
`timescale 1ns/1ps

module kd_search_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // APB configuration port
  input  logic                                   psel,
  input  logic                                   penable,
  input  logic                                   pwrite,
  input  logic [kd_tree_pkg::apb_addr_width-1:0] paddr,
  input  logic [31:0]                            pwdata,
  output logic [31:0]                            prdata,
  output logic                                   pready,
  output logic                                   pslverr,
  // Query lanes
  input  logic                                   query_valid,
  input  kd_tree_pkg::patch_u                    query_patch,
  input  logic                                   query_valid_two,
  input  kd_tree_pkg::patch_u                    query_patch_two,
  // Leaf results
  output logic                                   leaf_valid,
  output logic [kd_tree_pkg::leaf_id_width-1:0]  leaf_id,
  output logic                                   leaf_valid_two,
  output logic [kd_tree_pkg::leaf_id_width-1:0]  leaf_id_two
);

  logic [kd_tree_pkg::num_nodes-1:0]                          node_wen;   // Per-node write strobe
  logic [kd_tree_pkg::storage_width-1:0]                      node_wdata; // Shared write word
  logic [kd_tree_pkg::num_nodes*kd_tree_pkg::storage_width-1:0] node_rdata; // All readback words

  node_config_apb u_cfg (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .node_wen   (node_wen),
    .node_wdata (node_wdata),
    .node_rdata (node_rdata)
  );

  kd_tree u_tree (
    .clk             (clk),
    .rst_n           (rst_n),
    .node_wen        (node_wen),
    .node_wdata      (node_wdata),
    .query_valid     (query_valid),
    .query_patch     (query_patch),
    .query_valid_two (query_valid_two),
    .query_patch_two (query_patch_two),
    .node_rdata      (node_rdata),
    .leaf_valid      (leaf_valid),
    .leaf_id         (leaf_id),
    .leaf_valid_two  (leaf_valid_two),
    .leaf_id_two     (leaf_id_two)
  );

endmodule

/* kd_tree.sv */
`timescale 1ns/1ps

module kd_tree (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic [kd_tree_pkg::num_nodes-1:0]                         node_wen,
  input  logic [kd_tree_pkg::storage_width-1:0]                     node_wdata,
  input  logic                                                      query_valid,
  input  kd_tree_pkg::patch_u                                       query_patch,
  input  logic                                                      query_valid_two,
  input  kd_tree_pkg::patch_u                                       query_patch_two,
  output logic [kd_tree_pkg::num_nodes*kd_tree_pkg::storage_width-1:0] node_rdata,
  output logic                                                      leaf_valid,
  output logic [kd_tree_pkg::leaf_id_width-1:0]                     leaf_id,
  output logic                                                      leaf_valid_two,
  output logic [kd_tree_pkg::leaf_id_width-1:0]                     leaf_id_two
);

  // Valids in heap order, slot 0 is the root input, slots 7..14 the leaves
  logic [kd_tree_pkg::num_slots-1:0] slot_v;
  logic [kd_tree_pkg::num_slots-1:0] slot_v_two;

  // One register stage per level, bits 0 / 2..1 / 6..3
  logic [kd_tree_pkg::num_nodes-1:0] stage_v_q;
  logic [kd_tree_pkg::num_nodes-1:0] stage_v_q_two;

  kd_tree_pkg::patch_u patch_q     [kd_tree_pkg::tree_levels];
  kd_tree_pkg::patch_u patch_q_two [kd_tree_pkg::tree_levels];

  logic [kd_tree_pkg::num_leaves-1:0] leaf_v;
  logic [kd_tree_pkg::num_leaves-1:0] leaf_v_two;

  // One-hot leaf vector to leaf number
  function automatic logic [kd_tree_pkg::leaf_id_width-1:0] leaf_encode(
    input logic [kd_tree_pkg::num_leaves-1:0] v
  );
    logic [kd_tree_pkg::leaf_id_width-1:0] id;
    id = '0;
    for (int i = 0; i < kd_tree_pkg::num_leaves; i++) begin
      if (v[i]) begin
        id = i[kd_tree_pkg::leaf_id_width-1:0];
      end
    end
    return id;
  endfunction

  assign slot_v[0]     = query_valid;     // Enters at the root
  assign slot_v_two[0] = query_valid_two;

  // Valid stages
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_v_q     <= '0;
      stage_v_q_two <= '0;
    end else begin
      stage_v_q     <= slot_v[kd_tree_pkg::num_nodes-1:0];     // Node outputs move down a level
      stage_v_q_two <= slot_v_two[kd_tree_pkg::num_nodes-1:0];
    end
  end

  // Patch stages travel beside their valids, flat view
  always_ff @(posedge clk) begin
    patch_q[0].flat     <= query_patch.flat;
    patch_q_two[0].flat <= query_patch_two.flat;
    for (int l = 1; l < kd_tree_pkg::tree_levels; l++) begin
      patch_q[l].flat     <= patch_q[l-1].flat;
      patch_q_two[l].flat <= patch_q_two[l-1].flat;
    end
  end

  // Node n feeds slots 2n+1 (left) and 2n+2 (right)
  for (genvar n = 0; n < kd_tree_pkg::num_nodes; n++) begin : g_node
    internal_node u_node (
      .clk             (clk),
      .rst_n           (rst_n),
      .wen             (node_wen[n]),
      .valid           (stage_v_q[n]),
      .valid_two       (stage_v_q_two[n]),
      .wdata           (node_wdata),
      .patch_in        (patch_q[$clog2(n + 2) - 1]),     // Level of node n
      .patch_in_two    (patch_q_two[$clog2(n + 2) - 1]),
      .valid_left      (slot_v[2*n + 1]),
      .valid_right     (slot_v[2*n + 2]),
      .valid_left_two  (slot_v_two[2*n + 1]),
      .valid_right_two (slot_v_two[2*n + 2]),
      .rdata           (node_rdata[n*kd_tree_pkg::storage_width +: kd_tree_pkg::storage_width])
    );
  end

  // Bottom node outputs after the third register
  assign leaf_v     = slot_v[kd_tree_pkg::num_slots-1 -: kd_tree_pkg::num_leaves];
  assign leaf_v_two = slot_v_two[kd_tree_pkg::num_slots-1 -: kd_tree_pkg::num_leaves];

  assign leaf_valid     = |leaf_v;
  assign leaf_valid_two = |leaf_v_two;
  assign leaf_id        = leaf_encode(leaf_v);
  assign leaf_id_two    = leaf_encode(leaf_v_two);

  // Each patch occupies at most one node per level in each lane
  // Root stage is a single bit
  for (genvar l = 1; l < kd_tree_pkg::tree_levels; l++) begin : g_stage_chk
    a_stage_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(stage_v_q[(1 << l) - 1 +: (1 << l)]) &&
      $onehot0(stage_v_q_two[(1 << l) - 1 +: (1 << l)]))
      else $error("kd_tree: level %0d valid vector not one-hot", l);
  end

  a_leaf_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(leaf_v) && $onehot0(leaf_v_two))
    else $error("kd_tree: leaf vector not one-hot");

endmodule

/* kd_tree_pkg.sv */
package kd_tree_pkg;

  // Tree geometry
  localparam int num_dims      = 5;
  localparam int dim_width     = 11;
  localparam int patch_width   = num_dims * dim_width; // 55 bits per patch
  localparam int tree_levels   = 3;
  localparam int num_nodes     = 7;
  localparam int num_leaves    = 8;
  localparam int num_slots     = num_nodes + num_leaves; // Heap slots, nodes then leaves
  localparam int leaf_id_width = 3;

  // Node storage word
  localparam int storage_width = 22;
  localparam int idx_width     = 3; // Enough for 5 dimensions plus invalid codes
  localparam int pad_width     = storage_width - dim_width - idx_width;
  localparam logic [idx_width-1:0] idx_invalid = 3'd7; // Selects no dimension

  // APB address map, one word per node
  localparam int apb_addr_width = 8;
  localparam int node_addr_lsb  = 2; // Byte offset bits inside a word

  // One patch word seen two ways
  typedef union packed {
    logic [patch_width-1:0]                flat; // Pipeline registers
    logic [num_dims-1:0][dim_width-1:0]    dims; // dims[0] in the LSBs
  } patch_u;

  // Split parameters of one internal node
  typedef struct packed {
    logic signed [dim_width-1:0] median; // Bits 21..11
    logic [pad_width-1:0]        pad;    // Always zero on readback
    logic [idx_width-1:0]        idx;    // Bits 2..0
  } node_word_t;

endpackage

/* node_config_apb.sv */
`timescale 1ns/1ps

module node_config_apb (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic                                                      psel,
  input  logic                                                      penable,
  input  logic                                                      pwrite,
  input  logic [kd_tree_pkg::apb_addr_width-1:0]                    paddr,
  input  logic [31:0]                                               pwdata,
  output logic [31:0]                                               prdata,
  output logic                                                      pready,
  output logic                                                      pslverr,
  output logic [kd_tree_pkg::num_nodes-1:0]                         node_wen,
  output logic [kd_tree_pkg::storage_width-1:0]                     node_wdata,
  input  logic [kd_tree_pkg::num_nodes*kd_tree_pkg::storage_width-1:0] node_rdata
);

  logic access;  // APB access phase
  logic addr_ok; // Aligned and inside the node range
  logic [kd_tree_pkg::apb_addr_width-kd_tree_pkg::node_addr_lsb-1:0] node_num;

  assign access   = psel && penable;
  assign node_num = paddr[kd_tree_pkg::apb_addr_width-1:kd_tree_pkg::node_addr_lsb];
  assign addr_ok  = (paddr[kd_tree_pkg::node_addr_lsb-1:0] == '0) &&
                    (node_num < kd_tree_pkg::num_nodes);

  // Write strobe, one cycle per accepted write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      node_wen <= '0;
    end else begin
      for (int i = 0; i < kd_tree_pkg::num_nodes; i++) begin
        node_wen[i] <= access && pwrite && addr_ok && (node_num == i);
      end
    end
  end

  // Write data held for the strobe cycle
  always_ff @(posedge clk) begin
    if (access && pwrite) begin
      node_wdata <= pwdata[kd_tree_pkg::storage_width-1:0]; // High bits dropped
    end
  end

  // Readback mux, zero on bad address
  always_comb begin
    prdata = '0;
    if (access && !pwrite && addr_ok) begin
      prdata[kd_tree_pkg::storage_width-1:0] =
        node_rdata[node_num*kd_tree_pkg::storage_width +: kd_tree_pkg::storage_width];
    end
  end

  assign pready  = 1'b1;               // No wait states
  assign pslverr = access && !addr_ok;

  a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
    penable |-> psel)
    else $error("node_config_apb: penable without psel");

endmodule

/* tb_kd_search.sv */
`timescale 1ns/1ps

module tb_kd_search;

  localparam int cyc_reset = 10;
  // Cycle budget per test, reset first
  localparam int budget = cyc_reset + 60 + 60 + 60 + 120 + 160 + 80;

  logic clk = 1'b0;
  logic rst_n, psel, penable, pwrite, pready, pslverr;
  logic [7:0] paddr;
  logic [31:0] pwdata, prdata;
  logic query_valid, query_valid_two, leaf_valid, leaf_valid_two;
  kd_tree_pkg::patch_u query_patch, query_patch_two;
  logic [2:0] leaf_id, leaf_id_two;

  logic [2:0] model_idx [7];          // Mirror of each node's split dimension
  logic signed [10:0] model_med [7];  // Mirror of each node's median
  int exp_one [$];                    // Due cycle * 8 + leaf, lane one
  int exp_two [$];
  logic pop_one, pop_two;
  int cycle = 0;
  int errors = 0;
  int tests_ok = 0;
  int tests_bad = 0;
  integer seed = 32'h9d9fc144;

  kd_search_top u_dut (.*);

  always #4 clk = ~clk;
  always @(posedge clk) cycle <= cycle + 1;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Descend from the root, leaf = bottom position * 2 + went right
  function automatic int walk_tree(input logic [54:0] p);
    int n;
    logic right;
    logic signed [10:0] v;
    n = 0;
    right = 1'b0;
    for (int lvl = 0; lvl < 3; lvl++) begin
      v = '0;                                          // Index 5..7 slices to zero
      if (model_idx[n] < 5) v = p[model_idx[n] * 11 +: 11];
      right = !(v < model_med[n]);                     // Ties go right
      if (lvl < 2) n = 2 * n + 1 + right;
    end
    return (n - 3) * 2 + right;
  endfunction

  function automatic logic [31:0] node_word(input int idx, input int med);
    return {10'b0, med[10:0], 8'b0, idx[2:0]};
  endfunction

  function automatic logic [54:0] rand_patch();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[54:0];
  endfunction

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    @(posedge clk);
    psel <= 1'b1;
    pwrite <= 1'b1;
    paddr <= addr;
    pwdata <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);                                    // Access phase, no wait states
    check_val("pslverr", pslverr, exp_err);
    psel <= 1'b0;
    penable <= 1'b0;
    if (!exp_err) begin
      model_idx[addr / 4] = data[2:0];
      model_med[addr / 4] = data[21:11];
    end
  endtask

  task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp_data,
                          input logic exp_err);
    @(posedge clk);
    psel <= 1'b1;
    pwrite <= 1'b0;
    paddr <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    check_val("pready", pready, 1'b1);
    check_val("pslverr", pslverr, exp_err);
    check_val("prdata", prdata, exp_data);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic send_pair(input logic v1, input logic [54:0] p1,
                           input logic v2, input logic [54:0] p2);
    @(posedge clk);
    query_valid <= v1;
    query_patch <= p1;
    query_valid_two <= v2;
    query_patch_two <= p2;
    // Sampled on the next edge, leaf due three edges after that
    if (v1) exp_one.push_back((cycle + 4) * 8 + walk_tree(p1));
    if (v2) exp_two.push_back((cycle + 4) * 8 + walk_tree(p2));
  endtask

  task automatic send_query(input logic [54:0] p);
    send_pair(1'b1, p, 1'b0, '0);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    send_pair(1'b0, '0, 1'b0, '0);
    while ((exp_one.size() != 0 || exp_two.size() != 0) && waited < 8) begin
      @(posedge clk);
      waited++;
    end
    assert (exp_one.size() == 0 && exp_two.size() == 0) else begin
      $display("Leaf results still outstanding after %0d idle cycles", waited);
      errors++;
    end
    repeat (2) @(posedge clk);
  endtask

  task automatic check_lane(input string lane, input logic v, input logic [2:0] id,
                            input int n, input int front, output logic pop);
    pop = (n > 0) && (v || front / 8 <= cycle);
    assert (!v || n > 0) else begin
      $display("Unexpected result on %s at %0t", lane, $time);
      errors++;
    end
    assert (v || !pop) else begin
      $display("No result on %s at %0t when one was due", lane, $time);
      errors++;
    end
    if (v && pop) begin
      check_val(lane, id, front % 8);
      check_val({lane, " arrival cycle"}, cycle, front / 8);
    end
  endtask

  // Leaf monitor, both lanes every cycle
  always @(posedge clk) begin
    if (rst_n) begin
      check_lane("leaf_id", leaf_valid, leaf_id, exp_one.size(),
                 exp_one.size() ? exp_one[0] : 0, pop_one);
      check_lane("leaf_id_two", leaf_valid_two, leaf_id_two, exp_two.size(),
                 exp_two.size() ? exp_two[0] : 0, pop_two);
      if (pop_one) void'(exp_one.pop_front());
      if (pop_two) void'(exp_two.pop_front());
    end
  end

  task automatic end_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    for (int n = 0; n < 7; n++) apb_read(n * 4, 32'd7, 1'b0); // Index 7, median 0
    repeat (20) @(posedge clk);                                 // No stray leaf_valid
    end_test("reset state", e0);
  endtask

  task automatic test_config();
    int e0;
    logic [31:0] wr [7];
    e0 = errors;
    for (int n = 0; n < 7; n++) begin
      wr[n] = $random(seed);
      apb_write(n * 4, wr[n], 1'b0);
    end
    for (int n = 0; n < 7; n++) apb_read(n * 4, wr[n] & 32'h003f_f807, 1'b0);
    end_test("config round trip", e0);
  endtask

  task automatic test_routing();
    int e0;
    int mid;
    int idx_cfg [7] = '{0, 1, 1, 2, 3, 4, 2};              // Dims differ along each path
    int med_cfg [7] = '{0, -100, 200, -50, 37, -300, 511};
    logic [54:0] p;
    e0 = errors;
    for (int n = 0; n < 7; n++) apb_write(n * 4, node_word(idx_cfg[n], med_cfg[n]), 1'b0);
    for (int pos = 0; pos < 4; pos++) begin
      for (int off = -1; off <= 1; off++) begin
        p = rand_patch();
        mid = (pos < 2) ? 1 : 2;
        p[0 +: 11] = (pos < 2) ? med_cfg[0] - 1 : med_cfg[0];
        p[11 * idx_cfg[mid] +: 11] = (pos % 2) ? med_cfg[mid] : med_cfg[mid] - 1;
        p[11 * idx_cfg[pos + 3] +: 11] = med_cfg[pos + 3] + off; // Straddle bottom median
        send_query(p);
      end
    end
    drain();
    end_test("single lane routing", e0);
  endtask

  task automatic test_stream();
    int e0;
    logic v1, v2;
    e0 = errors;
    for (int n = 0; n < 7; n++) apb_write(n * 4, $random(seed), 1'b0);
    for (int i = 0; i < 64; i++) begin
      v1 = ($random(seed) % 5) != 0; // Occasional idle cycles
      v2 = ($random(seed) % 5) != 0;
      send_pair(v1, rand_patch(), v2, rand_patch());
    end
    drain();
    end_test("dual lane streaming", e0);
  endtask

  task automatic test_invalid_idx();
    int e0;
    e0 = errors;
    for (int k = 5; k <= 7; k++) begin
      apb_write(0, node_word(k, 100), 1'b0);              // Zero slice goes left
      repeat (4) send_query(rand_patch());
      drain();
      apb_write(0, node_word(k, -100), 1'b0);             // Zero slice goes right
      repeat (4) send_pair(1'b1, rand_patch(), 1'b1, rand_patch());
      drain();
    end
    end_test("invalid index", e0);
  endtask

  task automatic test_addr_err();
    int e0;
    int bad [6] = '{28, 32, 252, 1, 6, 27};
    e0 = errors;
    for (int i = 0; i < 6; i++) begin
      apb_write(bad[i], 32'hffff_ffff, 1'b1);
      apb_read(bad[i], 32'd0, 1'b1);
    end
    for (int n = 0; n < 7; n++) apb_read(n * 4, {10'b0, model_med[n], 8'b0, model_idx[n]}, 1'b0);
    end_test("address errors", e0);
  endtask

  initial begin
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    query_valid = 1'b0;
    query_valid_two = 1'b0;
    query_patch = '0;
    query_patch_two = '0;
    for (int n = 0; n < 7; n++) begin
      model_idx[n] = 3'd7;
      model_med[n] = '0;
    end
    repeat (cyc_reset) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_config();
    test_routing();
    test_stream();
    test_invalid_idx();
    test_addr_err();
    $display("%0d tests passed, %0d tests failed", tests_ok, tests_bad);
    if (errors == 0 && tests_bad == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog at twice the summed budget
  initial begin
    #(budget * 2 * 8);
    $display("Run did not finish within %0d cycles", budget * 2);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* vlog.f */
kd_tree_pkg.sv
internal_node.sv
kd_tree.sv
node_config_apb.sv
kd_search_top.sv
tb_kd_search.sv
